// File: Bender.yml
package:
  name: rename_core

sources:
  - verilog/core_pkg.sv
  - verilog/isa_pkg.sv
  - verilog/inst_decoder.sv
  - verilog/free_list.sv
  - verilog/map_table.sv
  - verilog/reorder_buffer.sv
  - verilog/phys_regfile.sv
  - verilog/exec_unit.sv
  - verilog/rename_core.sv
  - target: test
    files:
      - test/rename_core_sva.sv
      - test/rename_core_tb.sv

// File: rename_core.f
verilog/core_pkg.sv
verilog/isa_pkg.sv
verilog/inst_decoder.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/reorder_buffer.sv
verilog/phys_regfile.sv
verilog/exec_unit.sv
verilog/rename_core.sv
test/rename_core_sva.sv
test/rename_core_tb.sv

// File: test/rename_core_sva.sv
`timescale 1ns/1ps

module rename_core_sva (
  input logic               clock,
  input logic               reset,
  input logic               inst_ready,
  input logic               halted,
  input logic               retire_valid,
  input logic               free_pop,
  input logic               free_empty,
  input logic               dispatch_en,
  input core_pkg::rob_idx_t tail_idx,
  input logic               wb_valid,
  input core_pkg::rob_idx_t wb_rob_idx
);
  logic [core_pkg::num_rob-1:0] wb_seen;  // Written back since allocation
  int                           error_count = 0;  // Assertion failures so far

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_seen <= '0;
    end else begin
      if (wb_valid) wb_seen[wb_rob_idx] <= 1'b1;
      if (dispatch_en) wb_seen[tail_idx] <= 1'b0;
    end
  end

  assert property (@(posedge clock) disable iff (reset) halted |-> !inst_ready)
    else begin
      error_count++;
      $error("inst_ready high after halt");
    end
  assert property (@(posedge clock) disable iff (reset) !(free_pop && free_empty))
    else begin
      error_count++;
      $error("Free list popped while empty");
    end
  assert property (@(posedge clock) disable iff (reset) $rose(retire_valid) |-> !halted)
    else begin
      error_count++;
      $error("retire_valid rose while halted");
    end
  assert property (@(posedge clock) disable iff (reset) wb_valid |-> !wb_seen[wb_rob_idx])
    else begin
      error_count++;
      $error("Second writeback to one ROB entry");
    end

endmodule

bind rename_core rename_core_sva sva_inst (
  .clock(clock), .reset(reset), .inst_ready(inst_ready), .halted(halted),
  .retire_valid(retire_valid), .free_pop(free_pop), .free_empty(free_empty),
  .dispatch_en(dispatch_en), .tail_idx(tail_idx), .wb_valid(wb_valid),
  .wb_rob_idx(wb_rob_idx)
);

// File: test/rename_core_tb.sv
`timescale 1ns/1ps

module rename_core_tb;
  localparam int num_rows       = 44;
  localparam int clock_period   = 40;
  localparam int timeout_cycles = 40 * num_rows + 200;

  logic             clock;
  logic             reset;
  logic             inst_valid;
  isa_pkg::inst_t   inst;
  logic             inst_ready, retire_valid, halted;
  core_pkg::areg_t  retire_areg;
  core_pkg::word_t  retire_value;
  core_pkg::count_t retired_count;

  // Stimulus table
  isa_pkg::opcode_t row_op  [num_rows];
  core_pkg::areg_t  row_rd  [num_rows];
  core_pkg::areg_t  row_rs1 [num_rows];
  core_pkg::areg_t  row_rs2 [num_rows];
  logic [15:0]      row_imm [num_rows];
  int               row_count, chain_first, chain_last, chain_stalls;
  core_pkg::areg_t  exp_areg_q [$];   // Expected retirements in program order
  core_pkg::word_t  exp_value_q [$];
  int               value_errors, other_errors, assert_errors;

  rename_core rename_core_inst (
    .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
    .inst_ready(inst_ready), .retire_valid(retire_valid), .retire_areg(retire_areg),
    .retire_value(retire_value), .halted(halted), .retired_count(retired_count)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(timeout_cycles * clock_period);
    $display("Watchdog expired, core did not halt within %0d cycles", timeout_cycles);
    $display("Checks failed");
    $finish;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input core_pkg::word_t got,
                            input core_pkg::word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_areg(input string name, input core_pkg::areg_t got,
                            input core_pkg::areg_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input core_pkg::count_t got,
                             input core_pkg::count_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // Table and model
  ////////////////////

  task automatic add_row(input isa_pkg::opcode_t op, input int rd, input int rs1,
                         input int rs2, input logic [15:0] imm);
    row_op[row_count]  = op;
    row_rd[row_count]  = core_pkg::areg_t'(rd);
    row_rs1[row_count] = core_pkg::areg_t'(rs1);
    row_rs2[row_count] = core_pkg::areg_t'(rs2);
    row_imm[row_count] = imm;
    row_count++;
  endtask

  task automatic build_table();
    isa_pkg::opcode_t alu_ops [3];
    int a;
    alu_ops = '{isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND};
    row_count = 0;
    for (int i = 0; i < 8; i++) begin  // Independent seeds of r0..r7
      add_row(isa_pkg::OP_ADDI, i, i, $urandom_range(15, 0), 16'($urandom()));
    end
    for (int i = 8; i < 16; i++) begin
      add_row(alu_ops[i % 3], i, $urandom_range(7, 0), $urandom_range(7, 0), 16'h0);
    end
    // MUL then an independent ADDI that finishes first and a consumer of both
    for (int k = 0; k < 5; k++) begin
      a = $urandom_range(15, 0);
      add_row(isa_pkg::OP_MUL, a, $urandom_range(15, 0), $urandom_range(15, 0), 16'h0);
      add_row(isa_pkg::OP_ADDI, a ^ 8, a ^ 8, 0, 16'($urandom()));
      add_row(alu_ops[k % 3], $urandom_range(15, 0), a, a ^ 8, 16'h0);
    end
    chain_first = row_count;
    for (int k = 0; k < 12; k++) begin  // Dependent MUL chain on r5
      add_row(isa_pkg::OP_MUL, 5, 5, $urandom_range(15, 0), 16'h0);
    end
    chain_last = row_count;
    add_row(isa_pkg::OP_HALT, 0, 0, 0, 16'h0);
  endtask

  task automatic compute_expected();
    core_pkg::word_t regs [core_pkg::num_areg];
    core_pkg::word_t a, b, v;
    foreach (regs[r]) regs[r] = '0;
    for (int i = 0; i < num_rows; i++) begin
      a = regs[row_rs1[i]];
      b = regs[row_rs2[i]];
      case (row_op[i])
        isa_pkg::OP_ADD:  v = a + b;
        isa_pkg::OP_SUB:  v = a - b;
        isa_pkg::OP_AND:  v = a & b;
        isa_pkg::OP_ADDI: v = a + {{16{row_imm[i][15]}}, row_imm[i]};
        isa_pkg::OP_MUL:  v = a * b;
        default:          v = '0;
      endcase
      if (row_op[i] != isa_pkg::OP_HALT) begin
        regs[row_rd[i]] = v;
        exp_areg_q.push_back(row_rd[i]);
        exp_value_q.push_back(v);
      end
    end
  endtask

  // Hold a row until the core takes it
  task automatic send_row(input int i);
    @(posedge clock);
    inst_valid <= 1'b1;
    inst       <= {row_op[i], row_rd[i], row_rs1[i], row_rs2[i], row_imm[i]};
    @(negedge clock);
    while (!inst_ready) begin
      if (i >= chain_first && i < chain_last) chain_stalls++;
      @(negedge clock);
    end
  endtask

  always @(negedge clock) begin : retire_monitor
    core_pkg::areg_t exp_areg;
    core_pkg::word_t exp_value;
    if (!reset && retire_valid === 1'b1) begin
      if (halted) begin
        other_errors++;
        $display("Retirement seen after the core halted at %0t", $time);
      end
      if (exp_areg_q.size() == 0) begin
        other_errors++;
        $display("Retirement at %0t with no instruction left to retire", $time);
      end else begin
        exp_areg  = exp_areg_q.pop_front();
        exp_value = exp_value_q.pop_front();
        check_areg("retire_areg", retire_areg, exp_areg);
        check_word("retire_value", retire_value, exp_value);
      end
    end
  end

  initial begin
    reset         = 1'b1;
    inst_valid    = 1'b0;
    inst          = '0;
    value_errors  = 0;
    other_errors  = 0;
    assert_errors = 0;
    chain_stalls  = 0;
    void'($urandom(18460));
    build_table();
    compute_expected();
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    @(negedge clock);  // State right after reset
    check_flag("inst_ready", inst_ready, 1'b1);
    check_flag("retire_valid", retire_valid, 1'b0);
    check_flag("halted", halted, 1'b0);
    check_count("retired_count", retired_count, '0);

    for (int i = 0; i < num_rows; i++) send_row(i);
    @(posedge clock);
    inst_valid <= 1'b0;

    while (!halted) @(negedge clock);
    repeat (5) begin
      @(negedge clock);
      check_flag("inst_ready", inst_ready, 1'b0);  // Stays closed after halt
    end
    check_count("retired_count", retired_count, core_pkg::count_t'(num_rows));
    if (exp_areg_q.size() != 0) begin
      other_errors++;
      $display("%0d expected retirements never appeared", exp_areg_q.size());
    end
    if (chain_stalls == 0) begin
      other_errors++;
      $display("MUL chain never stalled dispatch");
    end
    assert_errors = rename_core_inst.sva_inst.error_count;

    $display("Closing: %0d value errors, %0d other errors, %0d assertion errors",
             value_errors, other_errors, assert_errors);
    if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verilog/core_pkg.sv
package core_pkg;

  ////////////////////
  // Machine sizes
  ////////////////////

  localparam int num_areg    = 16;  // Architectural registers
  localparam int num_preg    = 32;  // Physical registers
  localparam int num_free    = num_preg - num_areg;
  localparam int num_rob     = 8;   // Reorder buffer entries
  localparam int mult_stages = 3;   // Multiplier latency

  ////////////////////
  // Widths
  ////////////////////

  // Architectural register index
  typedef logic [3:0]  areg_t;

  // Physical register index
  typedef logic [4:0]  preg_t;

  typedef logic [2:0]  rob_idx_t;   // ROB slot
  typedef logic [3:0]  free_idx_t;  // Free-list pointer

  // Data value
  typedef logic [31:0] word_t;

  // Retired-instruction count
  typedef logic [15:0] count_t;

endpackage

// File: verilog/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 load,
  input  isa_pkg::opcode_t     op,
  input  isa_pkg::exec_class_t exec_class,
  input  logic                 uses_rs2,
  input  core_pkg::preg_t      src1_preg,
  input  core_pkg::preg_t      src2_preg,
  input  core_pkg::preg_t      dest_preg,
  input  core_pkg::word_t      imm,
  input  core_pkg::rob_idx_t   rob_idx,
  input  logic                 src1_ready,
  input  logic                 src2_ready,
  input  core_pkg::word_t      src1_value,
  input  core_pkg::word_t      src2_value,
  output core_pkg::preg_t      slot_preg1,
  output core_pkg::preg_t      slot_preg2,
  output logic                 slot_free,
  output logic                 wb_valid,
  output core_pkg::preg_t      wb_preg,
  output core_pkg::rob_idx_t   wb_rob_idx,
  output core_pkg::word_t      wb_value
);
  localparam int last = core_pkg::mult_stages - 1;

  logic               slot_valid, slot_is_mul, slot_uses_rs2;
  isa_pkg::opcode_t   slot_op;
  core_pkg::preg_t    slot_dest;
  core_pkg::word_t    slot_imm;
  core_pkg::rob_idx_t slot_rob;
  logic               operands_ready, issue_alu, issue_mul;
  core_pkg::word_t    alu_result;
  logic               alu_valid;
  core_pkg::preg_t    alu_preg;
  core_pkg::rob_idx_t alu_rob;
  core_pkg::word_t    alu_value;
  logic [last:0]      mul_valid;
  core_pkg::preg_t    mul_preg  [core_pkg::mult_stages];
  core_pkg::rob_idx_t mul_rob   [core_pkg::mult_stages];
  core_pkg::word_t    mul_value [core_pkg::mult_stages];

  ////////////////////
  // Issue
  ////////////////////

  assign operands_ready = src1_ready && (src2_ready || !slot_uses_rs2);
  assign issue_mul      = slot_valid && slot_is_mul && operands_ready;
  // Multiplier owns the bus when its final stage fills on the next edge
  assign issue_alu      = slot_valid && !slot_is_mul && operands_ready && !mul_valid[last-1];
  assign slot_free      = !slot_valid || issue_alu || issue_mul;

  always_comb begin
    case (slot_op)
      isa_pkg::OP_SUB:  alu_result = src1_value - src2_value;
      isa_pkg::OP_AND:  alu_result = src1_value & src2_value;
      isa_pkg::OP_ADDI: alu_result = src1_value + slot_imm;
      default:          alu_result = src1_value + src2_value;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      slot_valid <= 1'b0;
      alu_valid  <= 1'b0;
      mul_valid  <= '0;
    end else begin
      if (load) slot_valid <= 1'b1;
      else if (issue_alu || issue_mul) slot_valid <= 1'b0;
      alu_valid <= issue_alu;
      mul_valid <= {mul_valid[last-1:0], issue_mul};  // Shift toward the bus
    end
  end

  // Slot and pipeline payload
  always_ff @(posedge clock) begin
    if (load) begin
      slot_op       <= op;
      slot_is_mul   <= (exec_class == isa_pkg::CLASS_MUL);
      slot_uses_rs2 <= uses_rs2;
      slot_preg1    <= src1_preg;
      slot_preg2    <= src2_preg;
      slot_dest     <= dest_preg;
      slot_imm      <= imm;
      slot_rob      <= rob_idx;
    end
    if (issue_alu) begin
      alu_preg  <= slot_dest;
      alu_rob   <= slot_rob;
      alu_value <= alu_result;
    end
    if (issue_mul) begin
      mul_preg[0]  <= slot_dest;
      mul_rob[0]   <= slot_rob;
      mul_value[0] <= src1_value * src2_value;  // Low 32 bits
    end
    for (int s = 1; s <= last; s++) begin
      mul_preg[s]  <= mul_preg[s-1];
      mul_rob[s]   <= mul_rob[s-1];
      mul_value[s] <= mul_value[s-1];
    end
  end

  // Result bus, never both at once
  assign wb_valid   = alu_valid || mul_valid[last];
  assign wb_preg    = mul_valid[last] ? mul_preg[last]  : alu_preg;
  assign wb_rob_idx = mul_valid[last] ? mul_rob[last]   : alu_rob;
  assign wb_value   = mul_valid[last] ? mul_value[last] : alu_value;

endmodule

// File: verilog/free_list.sv
`timescale 1ns/1ps

module free_list (
  input  logic            clock,
  input  logic            reset,
  input  logic            pop,
  input  logic            push,
  input  core_pkg::preg_t push_preg,
  output core_pkg::preg_t head_preg,
  output logic            empty
);
  core_pkg::preg_t     queue [core_pkg::num_free];
  core_pkg::free_idx_t head;
  core_pkg::free_idx_t tail;
  logic [$clog2(core_pkg::num_free + 1)-1:0] count;  // 0 to num_free

  assign head_preg = queue[head];
  assign empty     = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      // Every preg above the identity map starts out free
      for (int i = 0; i < core_pkg::num_free; i++) begin
        queue[i] <= core_pkg::preg_t'(core_pkg::num_areg + i);
      end
      head  <= '0;
      tail  <= '0;
      count <= $bits(count)'(core_pkg::num_free);
    end else begin
      if (pop) begin
        head <= head + 1'b1;  // Wraps at num_free
      end
      if (push) begin
        queue[tail] <= push_preg;
        tail        <= tail + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

endmodule

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  isa_pkg::inst_t       inst,
  output core_pkg::areg_t      rd,
  output core_pkg::areg_t      rs1,
  output core_pkg::areg_t      rs2,
  output core_pkg::word_t      imm,
  output isa_pkg::opcode_t     op,
  output isa_pkg::exec_class_t exec_class,
  output logic                 writes_rd,
  output logic                 uses_rs2
);
  isa_pkg::opcode_t raw_op;

  assign raw_op = isa_pkg::opcode_t'(inst[isa_pkg::opcode_lsb +: 4]);
  assign rd     = inst[isa_pkg::rd_lsb  +: $bits(core_pkg::areg_t)];
  assign rs1    = inst[isa_pkg::rs1_lsb +: $bits(core_pkg::areg_t)];
  assign rs2    = inst[isa_pkg::rs2_lsb +: $bits(core_pkg::areg_t)];
  assign imm    = {{(32 - isa_pkg::imm_width){inst[isa_pkg::imm_width-1]}},
                   inst[isa_pkg::imm_width-1:0]};

  always_comb begin
    op         = raw_op;
    exec_class = isa_pkg::CLASS_ALU;
    uses_rs2   = 1'b1;
    case (raw_op)
      isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND: ;
      isa_pkg::OP_ADDI: uses_rs2 = 1'b0;        // Immediate replaces rs2
      isa_pkg::OP_MUL:  exec_class = isa_pkg::CLASS_MUL;
      default: begin                            // Unknown opcodes stop the core
        op         = isa_pkg::OP_HALT;
        exec_class = isa_pkg::CLASS_NONE;
        uses_rs2   = 1'b0;
      end
    endcase
  end

  assign writes_rd = (exec_class != isa_pkg::CLASS_NONE);

endmodule

// File: verilog/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] inst_t;

  // Field positions inside inst_t
  localparam int opcode_lsb = 28;
  localparam int rd_lsb     = 24;
  localparam int rs1_lsb    = 20;
  localparam int rs2_lsb    = 16;
  localparam int imm_width  = 16;  // Sign-extended on decode

  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_ADDI = 4'h3,
    OP_MUL  = 4'h4,
    OP_HALT = 4'hf
  } opcode_t;

  typedef enum logic [1:0] {
    CLASS_ALU  = 2'd0,
    CLASS_MUL  = 2'd1,
    CLASS_NONE = 2'd2   // HALT, no slot and no register
  } exec_class_t;

endpackage

// File: verilog/map_table.sv
`timescale 1ns/1ps

module map_table (
  input  logic            clock,
  input  logic            reset,
  input  core_pkg::areg_t rs1,
  input  core_pkg::areg_t rs2,
  input  core_pkg::areg_t rd,
  input  logic            rename_en,
  input  core_pkg::preg_t new_preg,
  output core_pkg::preg_t src1_preg,
  output core_pkg::preg_t src2_preg,
  output core_pkg::preg_t old_preg
);
  core_pkg::preg_t map [core_pkg::num_areg];

  // Reads see the mapping before this cycle's rename
  assign src1_preg = map[rs1];
  assign src2_preg = map[rs2];
  assign old_preg  = map[rd];   // Superseded preg, freed at retire

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < core_pkg::num_areg; i++) begin
        map[i] <= core_pkg::preg_t'(i);  // Identity
      end
    end else if (rename_en) begin
      map[rd] <= new_preg;
    end
  end

endmodule

// File: verilog/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile (
  input  logic            clock,
  input  logic            reset,
  input  logic            alloc,
  input  core_pkg::preg_t alloc_preg,
  input  logic            wb_valid,
  input  core_pkg::preg_t wb_preg,
  input  core_pkg::word_t wb_value,
  input  core_pkg::preg_t rd1_preg,
  input  core_pkg::preg_t rd2_preg,
  input  core_pkg::preg_t rd3_preg,
  output core_pkg::word_t rd1_value,
  output core_pkg::word_t rd2_value,
  output core_pkg::word_t rd3_value,
  output logic            rd1_ready,
  output logic            rd2_ready
);
  core_pkg::word_t              values [core_pkg::num_preg];
  logic [core_pkg::num_preg-1:0] ready;

  assign rd1_value = values[rd1_preg];  // Slot source 1
  assign rd2_value = values[rd2_preg];  // Slot source 2
  assign rd3_value = values[rd3_preg];  // Retiring result
  assign rd1_ready = ready[rd1_preg];
  assign rd2_ready = ready[rd2_preg];

  always_ff @(posedge clock) begin
    if (reset) begin
      // Architectural state starts as all zeros
      for (int i = 0; i < core_pkg::num_preg; i++) begin
        values[i] <= '0;
      end
      ready <= '1;
    end else begin
      if (alloc) ready[alloc_preg] <= 1'b0;  // Value now pending
      if (wb_valid) begin
        ready[wb_preg]  <= 1'b1;
        values[wb_preg] <= wb_value;
      end
    end
  end

endmodule

// File: verilog/rename_core.sv
`timescale 1ns/1ps

module rename_core (
  input  logic             clock,
  input  logic             reset,
  input  logic             inst_valid,
  input  isa_pkg::inst_t   inst,
  output logic             inst_ready,
  output logic             retire_valid,
  output core_pkg::areg_t  retire_areg,
  output core_pkg::word_t  retire_value,
  output logic             halted,
  output core_pkg::count_t retired_count
);
  core_pkg::areg_t      rd, rs1, rs2;
  core_pkg::word_t      imm;
  isa_pkg::opcode_t     op;
  isa_pkg::exec_class_t exec_class;
  logic                 writes_rd, uses_rs2, needs_slot;
  logic                 dispatch_en, free_pop, free_empty, free_push;
  core_pkg::preg_t      new_preg, old_preg, src1_preg, src2_preg, free_preg;
  core_pkg::preg_t      slot_preg1, slot_preg2, retire_preg;
  core_pkg::rob_idx_t   tail_idx, wb_rob_idx;
  logic                 rob_full, slot_free, src1_ready, src2_ready;
  core_pkg::word_t      src1_value, src2_value, wb_value;
  logic                 wb_valid;
  core_pkg::preg_t      wb_preg;

  ////////////////////
  // Dispatch
  ////////////////////

  assign needs_slot  = (exec_class != isa_pkg::CLASS_NONE);
  assign inst_ready  = !rob_full && !(writes_rd && free_empty) &&
                       !(needs_slot && !slot_free) && !halted;
  assign dispatch_en = inst_valid && inst_ready;
  assign free_pop    = dispatch_en && writes_rd;  // Also the rename and alloc strobe

  inst_decoder decoder_inst (
    .inst(inst), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .op(op),
    .exec_class(exec_class), .writes_rd(writes_rd), .uses_rs2(uses_rs2)
  );

  free_list free_list_inst (
    .clock(clock), .reset(reset), .pop(free_pop), .push(free_push),
    .push_preg(free_preg), .head_preg(new_preg), .empty(free_empty)
  );

  map_table map_table_inst (
    .clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd),
    .rename_en(free_pop), .new_preg(new_preg),
    .src1_preg(src1_preg), .src2_preg(src2_preg), .old_preg(old_preg)
  );

  reorder_buffer rob_inst (
    .clock(clock), .reset(reset), .alloc(dispatch_en), .alloc_areg(rd),
    .alloc_new_preg(new_preg), .alloc_old_preg(old_preg), .alloc_writes(writes_rd),
    .alloc_halt(op == isa_pkg::OP_HALT), .wb_valid(wb_valid), .wb_rob_idx(wb_rob_idx),
    .tail_idx(tail_idx), .full(rob_full), .retire_valid(retire_valid),
    .retire_areg(retire_areg), .retire_preg(retire_preg), .free_push(free_push),
    .free_preg(free_preg), .halted(halted), .retired_count(retired_count)
  );

  phys_regfile regfile_inst (
    .clock(clock), .reset(reset), .alloc(free_pop), .alloc_preg(new_preg),
    .wb_valid(wb_valid), .wb_preg(wb_preg), .wb_value(wb_value),
    .rd1_preg(slot_preg1), .rd2_preg(slot_preg2), .rd3_preg(retire_preg),
    .rd1_value(src1_value), .rd2_value(src2_value), .rd3_value(retire_value),
    .rd1_ready(src1_ready), .rd2_ready(src2_ready)
  );

  exec_unit exec_inst (
    .clock(clock), .reset(reset), .load(dispatch_en && needs_slot), .op(op),
    .exec_class(exec_class), .uses_rs2(uses_rs2), .src1_preg(src1_preg),
    .src2_preg(src2_preg), .dest_preg(new_preg), .imm(imm), .rob_idx(tail_idx),
    .src1_ready(src1_ready), .src2_ready(src2_ready), .src1_value(src1_value),
    .src2_value(src2_value), .slot_preg1(slot_preg1), .slot_preg2(slot_preg2),
    .slot_free(slot_free), .wb_valid(wb_valid), .wb_preg(wb_preg),
    .wb_rob_idx(wb_rob_idx), .wb_value(wb_value)
  );

endmodule

// File: verilog/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
  input  logic               clock,
  input  logic               reset,
  input  logic               alloc,
  input  core_pkg::areg_t    alloc_areg,
  input  core_pkg::preg_t    alloc_new_preg,
  input  core_pkg::preg_t    alloc_old_preg,
  input  logic               alloc_writes,
  input  logic               alloc_halt,
  input  logic               wb_valid,
  input  core_pkg::rob_idx_t wb_rob_idx,
  output core_pkg::rob_idx_t tail_idx,
  output logic               full,
  output logic               retire_valid,
  output core_pkg::areg_t    retire_areg,
  output core_pkg::preg_t    retire_preg,
  output logic               free_push,
  output core_pkg::preg_t    free_preg,
  output logic               halted,
  output core_pkg::count_t   retired_count
);
  core_pkg::areg_t    e_areg     [core_pkg::num_rob];
  core_pkg::preg_t    e_new_preg [core_pkg::num_rob];
  core_pkg::preg_t    e_old_preg [core_pkg::num_rob];
  logic [core_pkg::num_rob-1:0] e_writes;
  logic [core_pkg::num_rob-1:0] e_halt;
  logic [core_pkg::num_rob-1:0] e_done;
  core_pkg::rob_idx_t head;
  core_pkg::rob_idx_t tail;
  logic [$clog2(core_pkg::num_rob + 1)-1:0] count;
  logic               retire_en;

  ////////////////////
  // Head and retire
  ////////////////////

  assign retire_en    = (count != '0) && e_done[head] && !halted;
  assign retire_valid = retire_en && !e_halt[head];  // HALT gives no pulse
  assign retire_areg  = e_areg[head];
  assign retire_preg  = e_new_preg[head];
  assign free_push    = retire_en && e_writes[head];
  assign free_preg    = e_old_preg[head];
  assign tail_idx     = tail;
  assign full         = (count == $bits(count)'(core_pkg::num_rob));

  // Entry payload
  always_ff @(posedge clock) begin
    if (alloc) begin
      e_areg[tail]     <= alloc_areg;
      e_new_preg[tail] <= alloc_new_preg;
      e_old_preg[tail] <= alloc_old_preg;
      e_writes[tail]   <= alloc_writes;
      e_halt[tail]     <= alloc_halt;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      e_done        <= '0;
      head          <= '0;
      tail          <= '0;
      count         <= '0;
      halted        <= 1'b0;
      retired_count <= '0;
    end else begin
      if (wb_valid) e_done[wb_rob_idx] <= 1'b1;
      if (alloc) begin
        e_done[tail] <= alloc_halt;  // HALT is born done
        tail         <= tail + 1'b1;
      end
      if (retire_en) begin
        head          <= head + 1'b1;
        retired_count <= retired_count + 1'b1;
        if (e_halt[head]) halted <= 1'b1;
      end
      case ({alloc, retire_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule
